//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_mandel
FILELIST   = tb.f
PASS_MSG   = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- escape_iterator.sv
`timescale 1ns/1ns

module escape_iterator #(
	parameter int MAX_ITER = 1000
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                pt_valid,
	input  mandel_pkg::point_t  pt,
	output logic                pt_ready,
	output logic                res_valid,
	output mandel_pkg::result_t res,
	input  logic                res_ready
);

	localparam mandel_pkg::count_t ITER_LAST = mandel_pkg::count_t'(MAX_ITER);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CALC,
		S_HOLD
	} state_t;

	state_t state;

	// Point under work and its orbit
	mandel_pkg::fix_t cr;
	mandel_pkg::fix_t ci;
	mandel_pkg::fix_t zr;
	mandel_pkg::fix_t zi;
	mandel_pkg::count_t step;

	// One step of z = z^2 + c
	mandel_pkg::fix_t zr_sq;
	mandel_pkg::fix_t zi_sq;
	mandel_pkg::fix_t zri;
	mandel_pkg::fix_t zr_nx;
	mandel_pkg::fix_t zi_nx;
	mandel_pkg::fix_t mag_nx;
	mandel_pkg::count_t step_nx;
	logic escaped;
	logic finish;

	////////////////////////////////////////////////////////////
	// Step datapath
	////////////////////////////////////////////////////////////

	assign zr_sq = mandel_pkg::fix_mul(zr, zr);
	assign zi_sq = mandel_pkg::fix_mul(zi, zi);
	assign zri   = mandel_pkg::fix_mul(zr, zi);

	// Everything wraps at 27 bits
	assign zr_nx = zr_sq - zi_sq + cr;
	assign zi_nx = (zri <<< 1) + ci;

	// Squared magnitude of the new z
	assign mag_nx = mandel_pkg::fix_mul(zr_nx, zr_nx)
		+ mandel_pkg::fix_mul(zi_nx, zi_nx);

	assign escaped = (mag_nx > mandel_pkg::FIX_FOUR);
	assign step_nx = step + 1'b1;
	assign finish  = escaped || (step_nx == ITER_LAST);

	// Handshake straight from the state
	assign pt_ready  = (state == S_IDLE);
	assign res_valid = (state == S_HOLD);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (pt_valid) begin
						state <= S_CALC;
					end
				end
				S_CALC: begin
					if (finish) begin
						state <= S_HOLD;
					end
				end
				// Result parked until the writer takes it
				S_HOLD: begin
					if (res_ready) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Orbit registers, z starts at zero
	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (pt_valid) begin
					cr      <= pt.cr;
					ci      <= pt.ci;
					zr      <= '0;
					zi      <= '0;
					step    <= '0;
					res.adr <= pt.adr;
				end
			end
			S_CALC: begin
				if (finish) begin
					res.count <= step_nx;
				end else begin
					zr   <= zr_nx;
					zi   <= zi_nx;
					step <= step_nx;
				end
			end
			default: begin
			end
		endcase
	end

	// Count lands in 1..limit
	assert property (@(posedge clk) disable iff (rst)
		res_valid |-> (res.count != '0) && (res.count <= ITER_LAST));

endmodule

//--- mandel_pkg.sv
package mandel_pkg;

	////////////////////////////////////////////////////////////
	// Fixed point, 4.23 two's complement
	////////////////////////////////////////////////////////////

	localparam int FRAC_BITS = 23;

	typedef logic signed [26:0] fix_t;

	// 1.0 and the escape bound 4.0
	localparam fix_t FIX_ONE  = 27'sd8388608;
	localparam fix_t FIX_FOUR = 27'sd33554432;

	// Frame buffer word address and iteration count
	typedef logic [18:0] adr_t;
	typedef logic [9:0]  count_t;

	////////////////////////////////////////////////////////////
	// View selection
	////////////////////////////////////////////////////////////

	// Zoom codes
	localparam logic [1:0] ZOOM_FULL = 2'd0;
	localparam logic [1:0] ZOOM_NEAR = 2'd1;
	localparam logic [1:0] ZOOM_DEEP = 2'd2;

	typedef struct packed {
		logic [1:0] zoom;
		logic       pan_right;
		logic       pan_down;
	} view_t;

	// Upper left corner, -2.0 + 1.0i
	localparam fix_t VIEW_CR_START = -27'sd16777216;
	localparam fix_t VIEW_CI_START = FIX_ONE;

	// Column steps 3/640, 1.5/640, 0.75/640
	localparam fix_t VIEW_DX_FULL = 27'sd39321;
	localparam fix_t VIEW_DX_ZOOM = 27'sd19660;
	localparam fix_t VIEW_DX_DEEP = 27'sd9830;

	// Row steps 2/480, 1/480, 0.5/480
	localparam fix_t VIEW_DY_FULL = 27'sd34952;
	localparam fix_t VIEW_DY_ZOOM = 27'sd17476;
	localparam fix_t VIEW_DY_DEEP = 27'sd8738;

	// Pan shifts the corner by one unit
	localparam fix_t VIEW_PAN = FIX_ONE;

	////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////

	// Scanner to iterator
	typedef struct packed {
		adr_t adr;
		fix_t cr;
		fix_t ci;
	} point_t;

	// Iterator to writer
	typedef struct packed {
		adr_t   adr;
		count_t count;
	} result_t;

	// Color byte, RGB 3-3-2
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb_t;

	// Bus side reads raw, color map writes rgb
	typedef union packed {
		logic [7:0] raw;
		rgb_t       rgb;
	} pixel_u;

	// 4.23 multiply, full product then drop fraction and top bits
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [53:0] prod;
		prod = a * b;
		return prod[FRAC_BITS+26:FRAC_BITS];
	endfunction

endpackage

//--- mandel_top.sv
`timescale 1ns/1ns

module mandel_top #(
	parameter int WIDTH    = 640,
	parameter int HEIGHT   = 480,
	parameter int MAX_ITER = 1000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  mandel_pkg::view_t  view,
	output logic               busy,
	output logic               frame_done,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output mandel_pkg::adr_t   wb_adr,
	output mandel_pkg::pixel_u wb_dat,
	input  logic               wb_ack
);

	////////////////////////////////////////////////////////////
	// Scan, iterate, write
	////////////////////////////////////////////////////////////

	// Scanner to iterator
	logic pt_valid;
	logic pt_ready;
	mandel_pkg::point_t pt;

	// Iterator to writer
	logic res_valid;
	logic res_ready;
	mandel_pkg::result_t res;

	pixel_scanner #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT)
	) scan_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.view(view),
		.frame_done(frame_done),
		.busy(busy),
		.pt_valid(pt_valid),
		.pt(pt),
		.pt_ready(pt_ready)
	);

	escape_iterator #(
		.MAX_ITER(MAX_ITER)
	) iter_i (
		.clk(clk),
		.rst(rst),
		.pt_valid(pt_valid),
		.pt(pt),
		.pt_ready(pt_ready),
		.res_valid(res_valid),
		.res(res),
		.res_ready(res_ready)
	);

	// Also closes the frame back at the scanner
	pixel_writer #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT),
		.MAX_ITER(MAX_ITER)
	) write_i (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res(res),
		.res_ready(res_ready),
		.frame_done(frame_done),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

endmodule

//--- pixel_scanner.sv
`timescale 1ns/1ns

module pixel_scanner #(
	parameter int WIDTH  = 640,
	parameter int HEIGHT = 480
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  mandel_pkg::view_t  view,
	input  logic               frame_done,
	output logic               busy,
	output logic               pt_valid,
	output mandel_pkg::point_t pt,
	input  logic               pt_ready
);

	localparam int COL_W = $clog2(WIDTH + 1);
	localparam int ROW_W = $clog2(HEIGHT + 1);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(WIDTH - 1);
	localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(HEIGHT - 1);

	// Decoded view, valid in the start cycle
	mandel_pkg::fix_t cr_sel;
	mandel_pkg::fix_t ci_sel;
	mandel_pkg::fix_t dx_sel;
	mandel_pkg::fix_t dy_sel;

	// View held for the whole frame
	mandel_pkg::fix_t cr_row;
	mandel_pkg::fix_t dx;
	mandel_pkg::fix_t dy;

	// Raster position
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	logic launch;
	logic take;
	logic last_pt;
	logic row_end;

	// New frame only when idle
	assign launch  = start && !busy;
	assign take    = pt_valid && pt_ready;
	assign row_end = (col == COL_LAST);
	assign last_pt = row_end && (row == ROW_LAST);

	////////////////////////////////////////////////////////////
	// View decode
	////////////////////////////////////////////////////////////

	always_comb begin
		case (view.zoom)
			mandel_pkg::ZOOM_NEAR: begin
				dx_sel = mandel_pkg::VIEW_DX_ZOOM;
				dy_sel = mandel_pkg::VIEW_DY_ZOOM;
			end
			mandel_pkg::ZOOM_DEEP: begin
				dx_sel = mandel_pkg::VIEW_DX_DEEP;
				dy_sel = mandel_pkg::VIEW_DY_DEEP;
			end
			mandel_pkg::ZOOM_FULL: begin
				dx_sel = mandel_pkg::VIEW_DX_FULL;
				dy_sel = mandel_pkg::VIEW_DY_FULL;
			end
			// Unused code 3 falls back to full view
			default: begin
				dx_sel = mandel_pkg::VIEW_DX_FULL;
				dy_sel = mandel_pkg::VIEW_DY_FULL;
			end
		endcase
		// Pan right moves real start up, pan down moves imag start down
		cr_sel = mandel_pkg::VIEW_CR_START;
		ci_sel = mandel_pkg::VIEW_CI_START;
		if (view.pan_right) begin
			cr_sel = cr_sel + mandel_pkg::VIEW_PAN;
		end
		if (view.pan_down) begin
			ci_sel = ci_sel - mandel_pkg::VIEW_PAN;
		end
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			pt_valid <= 1'b0;
			col      <= '0;
			row      <= '0;
		end else if (launch) begin
			busy     <= 1'b1;
			pt_valid <= 1'b1;
			col      <= '0;
			row      <= '0;
		end else begin
			// Writer reports the last ack
			if (frame_done) begin
				busy <= 1'b0;
			end
			if (take) begin
				if (last_pt) begin
					pt_valid <= 1'b0;
				end else if (row_end) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Point payload, steps only on a transfer
	always_ff @(posedge clk) begin
		if (launch) begin
			cr_row <= cr_sel;
			dx     <= dx_sel;
			dy     <= dy_sel;
			pt.adr <= '0;
			pt.cr  <= cr_sel;
			pt.ci  <= ci_sel;
		end else if (take && !last_pt) begin
			pt.adr <= pt.adr + 1'b1;
			if (row_end) begin
				// Back to left edge, one row down
				pt.cr <= cr_row;
				pt.ci <= pt.ci - dy;
			end else begin
				pt.cr <= pt.cr + dx;
			end
		end
	end

	// Offered point held under back-pressure
	assert property (@(posedge clk) disable iff (rst)
		pt_valid && !pt_ready |=> pt_valid && $stable(pt));

endmodule

//--- pixel_writer.sv
`timescale 1ns/1ns

module pixel_writer #(
	parameter int WIDTH    = 640,
	parameter int HEIGHT   = 480,
	parameter int MAX_ITER = 1000
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                res_valid,
	input  mandel_pkg::result_t res,
	output logic                res_ready,
	output logic                frame_done,
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output mandel_pkg::adr_t    wb_adr,
	output mandel_pkg::pixel_u  wb_dat,
	input  logic                wb_ack
);

	localparam mandel_pkg::count_t LIMIT = mandel_pkg::count_t'(MAX_ITER);
	localparam mandel_pkg::adr_t ADR_LAST = mandel_pkg::adr_t'(WIDTH * HEIGHT - 1);

	mandel_pkg::pixel_u color;
	logic take;

	// One result at a time and none while a bus cycle runs
	assign res_ready = !wb_cyc;
	assign take      = res_valid && res_ready;

	// Write only master
	assign wb_we = wb_cyc;

	////////////////////////////////////////////////////////////
	// Count to color
	////////////////////////////////////////////////////////////

	always_comb begin
		if (res.count >= LIMIT) begin
			// Inside the set
			color.rgb = '{red: 3'd0, green: 3'd0, blue: 2'd0};
		end else if (res.count >= (LIMIT >> 2)) begin
			// Also covers limit/2 with the same color
			color.rgb = '{red: 3'd3, green: 3'd1, blue: 2'd0};
		end else if (res.count >= (LIMIT >> 3)) begin
			color.rgb = '{red: 3'd5, green: 3'd2, blue: 2'd1};
		end else if (res.count >= (LIMIT >> 4)) begin
			color.rgb = '{red: 3'd3, green: 3'd1, blue: 2'd1};
		end else if (res.count >= (LIMIT >> 5)) begin
			color.rgb = '{red: 3'd1, green: 3'd1, blue: 2'd1};
		end else if (res.count >= (LIMIT >> 6)) begin
			color.rgb = '{red: 3'd3, green: 3'd2, blue: 2'd2};
		end else begin
			// limit/128, limit/256 and below
			color.rgb = '{red: 3'd2, green: 3'd4, blue: 2'd2};
		end
	end

	////////////////////////////////////////////////////////////
	// Wishbone classic write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_cyc     <= 1'b0;
			wb_stb     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (take) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
			end else if (wb_stb && wb_ack) begin
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
				// Last pixel acked ends the frame
				frame_done <= (wb_adr == ADR_LAST);
			end
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (take) begin
			wb_adr <= res.adr;
			wb_dat <= color;
		end
	end

	// Strobe stays inside the cycle with address and data frozen until ack
	assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_dat));

endmodule

//--- tb.f
+incdir+.
mandel_pkg.sv
pixel_scanner.sv
escape_iterator.sv
pixel_writer.sv
mandel_top.sv
tb_mandel.sv

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Error tallies
////////////////////////////////////////////////////////////

// Wrong values on a DUT output or in the frame buffer
int value_errors = 0;
// Protocol or bookkeeping faults
int event_errors = 0;
// Wait loops that ran out
int timeout_errors = 0;

////////////////////////////////////////////////////////////
// Stimulus bits
////////////////////////////////////////////////////////////

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd90;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

// One step for each bit taken, MSB first
task automatic draw_bits(input int n, output int val);
	int i;
	val = 0;
	for (i = 0; i < n; i++) begin
		val = (val << 1) | int'(lfsr_state[15]);
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_pixel(input string name, input mandel_pkg::pixel_u got,
	input mandel_pkg::pixel_u exp);
	if (got.raw !== exp.raw) begin
		value_errors++;
		$display("error %s got %h expected %h at %0t ns", name, got.raw, exp.raw, $time);
	end
endtask

task automatic check_adr(input string name, input mandel_pkg::adr_t got,
	input mandel_pkg::adr_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("error %s got %h expected %h at %0t ns", name, got, exp, $time);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errors++;
		$display("error %s got %h expected %h at %0t ns", name, got, exp, $time);
	end
endtask

// Anything that is not a single wrong value
task automatic report_failure(input string msg);
	event_errors++;
	$display("%s at %0t ns", msg, $time);
endtask

task automatic report_timeout(input string what);
	timeout_errors++;
	$display("timed out waiting for %s at %0t ns", what, $time);
endtask

`endif

//--- tb_mandel.sv
`timescale 1ns/1ns

module tb_mandel;

	localparam int WIDTH    = 8;
	localparam int HEIGHT   = 4;
	localparam int MAX_ITER = 32;
	localparam int PIXELS   = WIDTH * HEIGHT;

	// Cycle budgets for the wait loops
	localparam int FRAME_TIMEOUT = 4000;
	localparam int WRITE_TIMEOUT = 2000;
	// Quiet window watched after a frame
	localparam int IDLE_CYCLES = 16;

	// 1.0 in 4.23 and the escape bound
	localparam longint ONE = 64'sd1 << 23;
	localparam mandel_pkg::fix_t ESCAPE = mandel_pkg::fix_t'(4 * ONE);

	logic clk;
	logic rst;
	logic start;
	mandel_pkg::view_t view;
	logic busy;
	logic frame_done;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	mandel_pkg::adr_t wb_adr;
	mandel_pkg::pixel_u wb_dat;
	logic wb_ack;

	`include "tb_checks.svh"

	// Frame buffer model
	mandel_pkg::pixel_u mem [PIXELS];
	logic written [PIXELS];
	int write_count;
	int done_count;
	bit random_delay;
	bit in_cycle;
	int wait_left;
	mandel_pkg::adr_t held_adr;
	mandel_pkg::pixel_u held_dat;

	mandel_top #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT),
		.MAX_ITER(MAX_ITER)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.view(view),
		.busy(busy),
		.frame_done(frame_done),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// 4.23 product with the fraction dropped and wrapping at 27 bits
	function automatic mandel_pkg::fix_t fixed_product(input mandel_pkg::fix_t a,
		input mandel_pkg::fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return mandel_pkg::fix_t'(p >>> 23);
	endfunction

	// First step whose new |z|^2 passes 4 or else the limit
	function automatic int escape_count(input mandel_pkg::fix_t cr,
		input mandel_pkg::fix_t ci);
		mandel_pkg::fix_t zr;
		mandel_pkg::fix_t zi;
		mandel_pkg::fix_t nr;
		mandel_pkg::fix_t ni;
		mandel_pkg::fix_t mag;
		int k;
		int count;
		zr = '0;
		zi = '0;
		k = 0;
		count = 0;
		while (count == 0) begin
			k++;
			nr = fixed_product(zr, zr) - fixed_product(zi, zi) + cr;
			// Twice the cross term
			ni = fixed_product(zr, zi) + fixed_product(zr, zi) + ci;
			mag = fixed_product(nr, nr) + fixed_product(ni, ni);
			if (mag > ESCAPE || k == MAX_ITER) begin
				count = k;
			end
			zr = nr;
			zi = ni;
		end
		return count;
	endfunction

	// First threshold reached among limit>>1 to limit>>8 wins
	function automatic mandel_pkg::pixel_u color_of(input int count);
		mandel_pkg::pixel_u p;
		int s;
		s = 1;
		while (s <= 8 && count < (MAX_ITER >> s)) begin
			s++;
		end
		if (count >= MAX_ITER) begin
			p.rgb = '{red: 3'd0, green: 3'd0, blue: 2'd0};
		end else begin
			case (s)
				1, 2: p.rgb = '{red: 3'd3, green: 3'd1, blue: 2'd0};
				3: p.rgb = '{red: 3'd5, green: 3'd2, blue: 2'd1};
				4: p.rgb = '{red: 3'd3, green: 3'd1, blue: 2'd1};
				5: p.rgb = '{red: 3'd1, green: 3'd1, blue: 2'd1};
				6: p.rgb = '{red: 3'd3, green: 3'd2, blue: 2'd2};
				default: p.rgb = '{red: 3'd2, green: 3'd4, blue: 2'd2};
			endcase
		end
		return p;
	endfunction

	function automatic mandel_pkg::pixel_u expected_pixel(input mandel_pkg::view_t v,
		input int col, input int row);
		longint cr0;
		longint ci0;
		longint dx;
		longint dy;
		// Corner -2 + 1i moved by one for each pan
		cr0 = -2 * ONE;
		ci0 = ONE;
		if (v.pan_right) begin
			cr0 = cr0 + ONE;
		end
		if (v.pan_down) begin
			ci0 = ci0 - ONE;
		end
		// Steps 3/640, 1.5/640, 0.75/640 and 2/480, 1/480, 0.5/480
		case (v.zoom)
			2'd1: begin
				dx = (3 * ONE) / 1280;
				dy = ONE / 480;
			end
			2'd2: begin
				dx = (3 * ONE) / 2560;
				dy = ONE / 960;
			end
			default: begin
				dx = (3 * ONE) / 640;
				dy = (2 * ONE) / 480;
			end
		endcase
		return color_of(escape_count(mandel_pkg::fix_t'(cr0 + col * dx),
			mandel_pkg::fix_t'(ci0 - row * dy)));
	endfunction

	function automatic mandel_pkg::view_t make_view(input logic [1:0] zoom,
		input logic right, input logic down);
		mandel_pkg::view_t v;
		v.zoom = zoom;
		v.pan_right = right;
		v.pan_down = down;
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Wishbone memory
	////////////////////////////////////////////////////////////

	task automatic store_write(input mandel_pkg::adr_t adr, input mandel_pkg::pixel_u dat);
		if (int'(adr) >= PIXELS) begin
			report_failure($sformatf("write to address %h outside the frame", adr));
		end else if (written[adr]) begin
			report_failure($sformatf("address %h written twice", adr));
		end else begin
			// Raster order means address equals write index
			check_adr("wb_adr", adr, mandel_pkg::adr_t'(write_count));
			written[adr] = 1'b1;
			mem[adr] = dat;
		end
		write_count++;
	endtask

	// Acts 1 ns after each edge like the stimulus
	always begin
		@(posedge clk);
		#1;
		if (rst) begin
			wb_ack = 1'b0;
			in_cycle = 1'b0;
		end else if (wb_ack) begin
			// Ack taken on the edge just passed
			wb_ack = 1'b0;
			in_cycle = 1'b0;
			check_bit("wb_cyc", wb_cyc, 1'b0);
			check_bit("wb_stb", wb_stb, 1'b0);
			store_write(held_adr, held_dat);
		end else if (wb_stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				held_adr = wb_adr;
				held_dat = wb_dat;
				wait_left = 0;
				if (random_delay) begin
					draw_bits(3, wait_left);
				end
			end else begin
				// Held until ack
				check_adr("wb_adr", wb_adr, held_adr);
				check_pixel("wb_dat", wb_dat, held_dat);
			end
			check_bit("wb_cyc", wb_cyc, 1'b1);
			check_bit("wb_we", wb_we, 1'b1);
			if (wait_left == 0) begin
				wb_ack = 1'b1;
			end else begin
				wait_left--;
			end
		end else if (in_cycle) begin
			in_cycle = 1'b0;
			report_failure("wb_stb dropped before ack");
		end else begin
			// Cycle only rises together with stb
			check_bit("wb_cyc", wb_cyc, 1'b0);
		end
		if (frame_done) begin
			done_count++;
		end
	end

	////////////////////////////////////////////////////////////
	// Frame helpers
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		int i;
		rst = 1'b1;
		start = 1'b0;
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
	endtask

	task automatic clear_memory();
		int i;
		for (i = 0; i < PIXELS; i++) begin
			written[i] = 1'b0;
			mem[i].raw = 8'h00;
		end
		write_count = 0;
		done_count = 0;
	endtask

	// One cycle start pulse with busy following on the next cycle
	task automatic launch_frame(input mandel_pkg::view_t v);
		clear_memory();
		@(posedge clk);
		#1;
		start = 1'b1;
		view = v;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_bit("busy", busy, 1'b1);
	endtask

	task automatic compare_frame(input mandel_pkg::view_t v);
		int a;
		for (a = 0; a < PIXELS; a++) begin
			if (!written[a]) begin
				report_failure($sformatf("pixel %0d never written", a));
			end else begin
				check_pixel($sformatf("wb_dat[%0d]", a), mem[a],
					expected_pixel(v, a % WIDTH, a / WIDTH));
			end
		end
	endtask

	// Optional stray start with another view partway through
	task automatic finish_frame(input mandel_pkg::view_t v, input bit stray_start);
		int n;
		n = 0;
		while (!frame_done && n < FRAME_TIMEOUT) begin
			check_bit("busy", busy, 1'b1);
			if (stray_start) begin
				start = (n == 10);
				if (n == 10) begin
					view = make_view(2'd2, 1'b1, 1'b1);
				end
			end
			@(posedge clk);
			#1;
			n++;
		end
		start = 1'b0;
		if (!frame_done) begin
			report_timeout("frame_done");
		end else begin
			// Pulse is one cycle and busy drops after it
			@(posedge clk);
			#1;
			check_bit("frame_done", frame_done, 1'b0);
			check_bit("busy", busy, 1'b0);
			if (done_count != 1) begin
				report_failure($sformatf("frame_done pulsed %0d times", done_count));
			end
			compare_frame(v);
		end
	endtask

	task automatic render(input mandel_pkg::view_t v);
		launch_frame(v);
		finish_frame(v, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic full_view_frame();
		random_delay = 1'b0;
		apply_reset();
		render(make_view(2'd0, 1'b0, 1'b0));
	endtask

	task automatic zoomed_and_panned_frames();
		random_delay = 1'b0;
		apply_reset();
		render(make_view(2'd1, 1'b1, 1'b0));
		render(make_view(2'd1, 1'b0, 1'b1));
		render(make_view(2'd2, 1'b1, 1'b0));
		render(make_view(2'd2, 1'b0, 1'b1));
	endtask

	// Ack delays 0..7 from the LFSR
	task automatic slow_ack_frames();
		random_delay = 1'b1;
		apply_reset();
		render(make_view(2'd0, 1'b0, 1'b0));
		render(make_view(2'd1, 1'b1, 1'b0));
		random_delay = 1'b0;
	endtask

	task automatic ignored_second_start();
		mandel_pkg::view_t v;
		int n;
		v = make_view(2'd0, 1'b0, 1'b0);
		random_delay = 1'b0;
		apply_reset();
		launch_frame(v);
		finish_frame(v, 1'b1);
		// The stray start must not leave a second frame queued
		for (n = 0; n < IDLE_CYCLES; n++) begin
			@(posedge clk);
			#1;
			check_bit("busy", busy, 1'b0);
			check_bit("frame_done", frame_done, 1'b0);
		end
		if (write_count != PIXELS) begin
			report_failure($sformatf("%0d writes for a frame of %0d pixels",
				write_count, PIXELS));
		end
	endtask

	task automatic reset_during_frame();
		int n;
		random_delay = 1'b1;
		apply_reset();
		launch_frame(make_view(2'd1, 1'b0, 1'b0));
		n = 0;
		while (write_count < PIXELS / 2 && n < WRITE_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (write_count < PIXELS / 2) begin
			report_timeout("half a frame of writes");
		end
		apply_reset();
		check_bit("wb_cyc", wb_cyc, 1'b0);
		check_bit("wb_stb", wb_stb, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("frame_done", frame_done, 1'b0);
		render(make_view(2'd0, 1'b1, 1'b1));
		random_delay = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		view = '0;
		wb_ack = 1'b0;
		random_delay = 1'b0;
		in_cycle = 1'b0;
		wait_left = 0;
		clear_memory();
		full_view_frame();
		zoomed_and_panned_frames();
		slow_ack_frames();
		ignored_second_start();
		reset_during_frame();
		$display("value errors %0d, other errors %0d, timeouts %0d",
			value_errors, event_errors, timeout_errors);
		if (value_errors + event_errors + timeout_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
